// File: verilog/ddr_settings.svh
// DDR controller settings
`ifndef DDR_SETTINGS_SVH
`define DDR_SETTINGS_SVH

// memory geometry
`define DDR_DATA_W 16
`define DDR_ROW_W 13
`define DDR_COL_W 10
`define DDR_BA_W 2
// one bank-select bit, then row, then column
`define DDR_USR_ADDR_W 24

// beats per access
`define DDR_BURST_LEN 2
// clk cycles from READ to the first beat
`define DDR_CAS_CYC 3
// mode register latency field for CL 3
`define DDR_CAS_CODE 3'b011

// timing counts in clk cycles
// tRCD must be at least 2 since a state sits between ACTIVE and READ/WRITE
`define DDR_T_RP 4
`define DDR_T_MRD 3
`define DDR_T_RFC 15
`define DDR_T_RCD 4
`define DDR_T_WR 3
`define DDR_T_DQSS 2

// long waits, kept short for simulation
// real parts want 200 cycles after the DLL enable
`define DDR_DLL_WAIT_CYC 20
// stands in for the 200 us power-up wait
`define DDR_INIT_WAIT_CYC 50
// auto refresh interval
`define DDR_REFRESH_CYC 400

// width of the wait and interval counters
`define DDR_CNT_W 16

`endif

// File: verilog/ddr_pkg.sv
// DDR controller types
`include "ddr_settings.svh"

package ddr_pkg;

	// user side words
	typedef logic [`DDR_USR_ADDR_W-1:0] usr_addr_t;
	typedef logic [2*`DDR_DATA_W-1:0] usr_word_t;
	// one beat on the dq bus
	typedef logic [`DDR_DATA_W-1:0] dq_word_t;

	// address fields
	typedef logic [`DDR_ROW_W-1:0] row_t;
	typedef logic [`DDR_COL_W-1:0] col_t;
	typedef logic [`DDR_BA_W-1:0] ba_t;
	// the address pins carry a row, a column or a mode word
	typedef logic [`DDR_ROW_W-1:0] mem_addr_t;

	// command pins, all active low
	typedef struct packed {
		logic cs;
		logic ras;
		logic cas;
		logic we;
	} ddr_cmd_t;

	// everything the scheduler drives toward the part
	typedef struct packed {
		logic cke;
		ddr_cmd_t cmd;
		ba_t ba;
		mem_addr_t addr;
	} mem_bus_t;

	// operations requested during power-up
	typedef enum logic [2:0] {
		op_nop,
		op_precharge_all,
		op_load_ext_mode,
		op_load_mode_dll_rst,
		op_load_mode,
		op_auto_refresh
	} init_op_t;

	// power-up steps in issue order
	typedef enum logic [3:0] {
		is_settle,
		is_nop,
		is_pre_1,
		is_ext_mode,
		is_mode_dll_rst,
		is_pre_2,
		is_refresh_1,
		is_refresh_2,
		is_mode,
		is_done
	} init_state_t;

	// command scheduler states
	typedef enum logic [3:0] {
		cs_idle,
		cs_init_wait,
		cs_activate,
		cs_read,
		cs_read_data,
		cs_write,
		cs_write_data,
		cs_refresh,
		cs_recover
	} cmd_state_t;

endpackage

// File: verilog/ddr_init_seq.sv
// DDR power-up sequencer
`timescale 1ns/1ps
`include "ddr_settings.svh"

module ddr_init_seq (
	input  logic              clk,
	input  logic              rst,
	input  logic              op_done,
	output logic              init_req,
	output ddr_pkg::init_op_t init_op,
	output logic              init_done,
	output logic              cke_en
);
	import ddr_pkg::*;

	localparam logic [`DDR_CNT_W-1:0] settle_last = `DDR_CNT_W'(`DDR_INIT_WAIT_CYC - 1);

	init_state_t state;
	init_state_t next_step;
	logic [`DDR_CNT_W-1:0] settle_cnt;

	// operation carried by each step
	function automatic init_op_t step_op(input init_state_t s);
		init_op_t op;
		case (s)
			is_pre_1, is_pre_2: op = op_precharge_all;
			is_ext_mode: op = op_load_ext_mode;
			is_mode_dll_rst: op = op_load_mode_dll_rst;
			is_refresh_1, is_refresh_2: op = op_auto_refresh;
			is_mode: op = op_load_mode;
			default: op = op_nop;
		endcase
		return op;
	endfunction

	// fixed step order
	always_comb begin
		case (state)
			is_nop: next_step = is_pre_1;
			is_pre_1: next_step = is_ext_mode;
			is_ext_mode: next_step = is_mode_dll_rst;
			is_mode_dll_rst: next_step = is_pre_2;
			is_pre_2: next_step = is_refresh_1;
			is_refresh_1: next_step = is_refresh_2;
			is_refresh_2: next_step = is_mode;
			default: next_step = is_done;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= is_settle;
			settle_cnt <= '0;
			init_req <= 1'b0;
			init_op <= op_nop;
			init_done <= 1'b0;
			cke_en <= 1'b0;
		end else begin
			case (state)
				is_settle: begin
					// cke stays low for the whole settling wait
					if (settle_cnt == settle_last) begin
						state <= is_nop;
						cke_en <= 1'b1;
						init_req <= 1'b1;
						init_op <= op_nop;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				is_done: begin
					// parked until the next reset
				end
				default: begin
					// request held until the scheduler reports it finished
					if (op_done) begin
						state <= next_step;
						init_op <= step_op(next_step);
						if (next_step == is_done) begin
							init_req <= 1'b0;
							init_done <= 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: verilog/ddr_cmd_fsm.sv
// DDR command scheduler
`timescale 1ns/1ps
`include "ddr_settings.svh"

module ddr_cmd_fsm (
	input  logic               clk,
	input  logic               rst,
	input  logic               init_req,
	input  ddr_pkg::init_op_t  init_op,
	input  logic               init_done,
	input  logic               cke_en,
	output logic               op_done,
	input  logic               cmd_vld,
	input  logic               cmd_write,
	input  ddr_pkg::usr_addr_t addr,
	output ddr_pkg::mem_bus_t  mem,
	output logic               busy,
	output logic               ready,
	output logic               wr_start,
	output logic               rd_start
);
	import ddr_pkg::*;

	// cs ras cas we
	localparam ddr_cmd_t cmd_desel = '{cs: 1'b1, ras: 1'b1, cas: 1'b1, we: 1'b1};
	localparam ddr_cmd_t cmd_nop = '{cs: 1'b0, ras: 1'b1, cas: 1'b1, we: 1'b1};
	localparam ddr_cmd_t cmd_act = '{cs: 1'b0, ras: 1'b0, cas: 1'b1, we: 1'b1};
	localparam ddr_cmd_t cmd_read = '{cs: 1'b0, ras: 1'b1, cas: 1'b0, we: 1'b1};
	localparam ddr_cmd_t cmd_wr = '{cs: 1'b0, ras: 1'b1, cas: 1'b0, we: 1'b0};
	localparam ddr_cmd_t cmd_pre = '{cs: 1'b0, ras: 1'b0, cas: 1'b1, we: 1'b0};
	localparam ddr_cmd_t cmd_ref = '{cs: 1'b0, ras: 1'b0, cas: 1'b0, we: 1'b1};
	localparam ddr_cmd_t cmd_lmr = '{cs: 1'b0, ras: 1'b0, cas: 1'b0, we: 1'b0};

	// A10 means all banks on precharge and auto precharge on READ/WRITE
	localparam mem_addr_t a10_bit = mem_addr_t'(1 << 10);
	localparam logic [`DDR_CNT_W-1:0] refresh_last = `DDR_CNT_W'(`DDR_REFRESH_CYC - 1);

	cmd_state_t state;
	logic [`DDR_CNT_W-1:0] wait_cnt;
	logic [`DDR_CNT_W-1:0] refresh_cnt;
	logic refresh_due;
	logic refresh_tick;
	logic wait_over;
	logic accept;
	// latched user request
	ba_t lat_ba;
	col_t lat_col;
	logic lat_write;

	// counter load for a wait of n cycles where the state exit adds one
	function automatic logic [`DDR_CNT_W-1:0] wait_of(input int cycles);
		return `DDR_CNT_W'(cycles - 1);
	endfunction

	// base mode register with sequential bursts
	function automatic mem_addr_t mode_word(input logic dll_rst);
		mem_addr_t word;
		word = '0;
		word[2:0] = 3'($clog2(`DDR_BURST_LEN));
		word[6:4] = `DDR_CAS_CODE;
		word[8] = dll_rst;
		return word;
	endfunction

	assign wait_over = (wait_cnt == '0);
	assign refresh_tick = init_done && (refresh_cnt == refresh_last);
	assign accept = cmd_vld && ready && !busy;

	// refresh interval counter runs once power-up is finished
	always_ff @(posedge clk) begin
		if (rst) begin
			refresh_cnt <= '0;
			refresh_due <= 1'b0;
		end else begin
			if (refresh_tick) begin
				refresh_cnt <= '0;
			end else if (init_done) begin
				refresh_cnt <= refresh_cnt + 1'b1;
			end
			if (refresh_tick) begin
				refresh_due <= 1'b1;
			end else if (state == cs_refresh) begin
				refresh_due <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cs_idle;
			wait_cnt <= '0;
			busy <= 1'b0;
			ready <= 1'b0;
			op_done <= 1'b0;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
			mem.cke <= 1'b0;
			mem.cmd <= cmd_desel;
			mem.ba <= '0;
			mem.addr <= '0;
		end else begin
			// strobes and the command bus fall back every cycle
			op_done <= 1'b0;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
			mem.cke <= cke_en;
			mem.cmd <= cke_en ? cmd_nop : cmd_desel;
			ready <= init_done;
			case (state)
				cs_idle: begin
					if (refresh_due) begin
						busy <= 1'b1;
						state <= cs_refresh;
					end else if (!init_done) begin
						// op_done still high means the sequencer has not moved on yet
						if (init_req && !op_done) begin
							state <= cs_init_wait;
							case (init_op)
								op_precharge_all: begin
									mem.cmd <= cmd_pre;
									mem.addr <= a10_bit;
									wait_cnt <= wait_of(`DDR_T_RP);
								end
								op_load_ext_mode: begin
									// DLL enabled and full drive strength are both zero
									mem.cmd <= cmd_lmr;
									mem.ba <= ba_t'(1);
									mem.addr <= '0;
									wait_cnt <= wait_of(`DDR_DLL_WAIT_CYC);
								end
								op_load_mode_dll_rst: begin
									mem.cmd <= cmd_lmr;
									mem.ba <= ba_t'(0);
									mem.addr <= mode_word(1'b1);
									wait_cnt <= wait_of(`DDR_T_MRD);
								end
								op_load_mode: begin
									mem.cmd <= cmd_lmr;
									mem.ba <= ba_t'(0);
									mem.addr <= mode_word(1'b0);
									wait_cnt <= wait_of(`DDR_T_MRD);
								end
								op_auto_refresh: begin
									mem.cmd <= cmd_ref;
									wait_cnt <= wait_of(`DDR_T_RFC);
								end
								default: begin
									// plain NOP with cke now high
									wait_cnt <= wait_of(1);
								end
							endcase
						end
					end else if (accept) begin
						// top address bit picks bank 2 or bank 1
						lat_ba <= addr[`DDR_USR_ADDR_W-1] ? ba_t'(2) : ba_t'(1);
						lat_col <= addr[`DDR_COL_W-1:0];
						lat_write <= cmd_write;
						mem.cmd <= cmd_act;
						mem.ba <= addr[`DDR_USR_ADDR_W-1] ? ba_t'(2) : ba_t'(1);
						mem.addr <= addr[`DDR_ROW_W+`DDR_COL_W-1:`DDR_COL_W];
						busy <= 1'b1;
						wait_cnt <= wait_of(`DDR_T_RCD - 1);
						state <= cs_activate;
					end else if (refresh_tick) begin
						// raised early so no strobe slips in ahead of the refresh
						busy <= 1'b1;
					end
				end
				cs_init_wait: begin
					if (wait_over) begin
						op_done <= 1'b1;
						state <= cs_idle;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				cs_activate: begin
					// tRCD
					if (wait_over) begin
						state <= lat_write ? cs_write : cs_read;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				cs_read: begin
					mem.cmd <= cmd_read;
					mem.ba <= lat_ba;
					mem.addr <= a10_bit | mem_addr_t'(lat_col);
					wait_cnt <= wait_of(`DDR_CAS_CYC);
					state <= cs_read_data;
				end
				cs_read_data: begin
					// first beat is on dq_in when rd_start shows
					if (wait_over) begin
						rd_start <= 1'b1;
						wait_cnt <= wait_of(`DDR_BURST_LEN - 1 + `DDR_T_RP);
						state <= cs_recover;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				cs_write: begin
					mem.cmd <= cmd_wr;
					mem.ba <= lat_ba;
					mem.addr <= a10_bit | mem_addr_t'(lat_col);
					wr_start <= 1'b1;
					wait_cnt <= wait_of(`DDR_T_DQSS + `DDR_BURST_LEN);
					state <= cs_write_data;
				end
				cs_write_data: begin
					// runs to the end of the last beat and then through tWR and tRP
					if (wait_over) begin
						wait_cnt <= wait_of(`DDR_T_WR + `DDR_T_RP);
						state <= cs_recover;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				cs_refresh: begin
					mem.cmd <= cmd_ref;
					wait_cnt <= wait_of(`DDR_T_RFC);
					state <= cs_recover;
				end
				cs_recover: begin
					if (wait_over) begin
						// a refresh that came due during the transfer or comes due now goes first
						if (refresh_due || refresh_tick) begin
							state <= cs_refresh;
						end else begin
							busy <= 1'b0;
							state <= cs_idle;
						end
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: begin
					state <= cs_idle;
				end
			endcase
		end
	end

endmodule

// File: verilog/ddr_data_path.sv
// DDR data path
`timescale 1ns/1ps
`include "ddr_settings.svh"

module ddr_data_path (
	input  logic               clk,
	input  logic               rst,
	input  logic               wr_start,
	input  logic               rd_start,
	input  ddr_pkg::usr_word_t wr_data,
	input  ddr_pkg::dq_word_t  dq_in,
	output ddr_pkg::dq_word_t  dq_out,
	output logic               dq_oe,
	output logic [1:0]         dqs,
	output ddr_pkg::usr_word_t rd_data,
	output logic               rd_vld
);
	import ddr_pkg::*;

	// wr_line[k] is high k cycles after the WRITE command
	logic [`DDR_T_DQSS-1:0] wr_dly;
	logic [`DDR_T_DQSS:0] wr_line;
	logic beat_hi;
	logic beat_lo;
	dq_word_t wr_lo;
	dq_word_t rd_hi;
	logic rd_second;

	assign wr_line = {wr_dly, wr_start};
	// launch each beat one edge before its bus cycle
	assign beat_hi = wr_line[`DDR_T_DQSS-1];
	assign beat_lo = wr_line[`DDR_T_DQSS];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_dly <= '0;
			dq_oe <= 1'b0;
			dqs <= 2'b00;
			rd_second <= 1'b0;
			rd_vld <= 1'b0;
		end else begin
			wr_dly <= wr_line[`DDR_T_DQSS-1:0];
			dq_oe <= beat_hi || beat_lo;
			// both byte strobes flip once per beat
			if (beat_hi || beat_lo) begin
				dqs <= ~dqs;
			end
			rd_second <= rd_start;
			rd_vld <= rd_second;
		end
	end

	// beat data and read capture
	always_ff @(posedge clk) begin
		// high half goes out first, wr_data has to be stable until then
		if (beat_hi) begin
			dq_out <= wr_data[2*`DDR_DATA_W-1:`DDR_DATA_W];
			wr_lo <= wr_data[`DDR_DATA_W-1:0];
		end else if (beat_lo) begin
			dq_out <= wr_lo;
		end
		if (rd_start) begin
			rd_hi <= dq_in;
		end
		if (rd_second) begin
			rd_data <= {rd_hi, dq_in};
		end
	end

endmodule

// File: verilog/ddr_controller.sv
// DDR controller top
`timescale 1ns/1ps
`include "ddr_settings.svh"

module ddr_controller (
	input  logic               clk,
	input  logic               rst,
	input  logic               cmd_vld,
	input  logic               cmd_write,
	input  ddr_pkg::usr_addr_t addr,
	input  ddr_pkg::usr_word_t wr_data,
	input  ddr_pkg::dq_word_t  dq_in,
	output ddr_pkg::mem_bus_t  mem,
	output ddr_pkg::dq_word_t  dq_out,
	output logic               dq_oe,
	output logic [1:0]         dqs,
	output ddr_pkg::usr_word_t rd_data,
	output logic               rd_vld,
	output logic               busy,
	output logic               ready
);
	import ddr_pkg::*;

	// sequencer to scheduler
	logic init_req;
	init_op_t init_op;
	logic init_done;
	logic cke_en;
	logic op_done;
	// scheduler to data path
	logic wr_start;
	logic rd_start;

	ddr_init_seq ddr_init_seq_i (
		.clk       (clk),
		.rst       (rst),
		.op_done   (op_done),
		.init_req  (init_req),
		.init_op   (init_op),
		.init_done (init_done),
		.cke_en    (cke_en)
	);

	ddr_cmd_fsm ddr_cmd_fsm_i (
		.clk       (clk),
		.rst       (rst),
		.init_req  (init_req),
		.init_op   (init_op),
		.init_done (init_done),
		.cke_en    (cke_en),
		.op_done   (op_done),
		.cmd_vld   (cmd_vld),
		.cmd_write (cmd_write),
		.addr      (addr),
		.mem       (mem),
		.busy      (busy),
		.ready     (ready),
		.wr_start  (wr_start),
		.rd_start  (rd_start)
	);

	ddr_data_path ddr_data_path_i (
		.clk      (clk),
		.rst      (rst),
		.wr_start (wr_start),
		.rd_start (rd_start),
		.wr_data  (wr_data),
		.dq_in    (dq_in),
		.dq_out   (dq_out),
		.dq_oe    (dq_oe),
		.dqs      (dqs),
		.rd_data  (rd_data),
		.rd_vld   (rd_vld)
	);

endmodule

// File: dv/ddr_mem_model.sv
// DDR SDRAM behavioral model
`timescale 1ns/1ps
`include "ddr_settings.svh"

module ddr_mem_model (
	input  logic               clk,
	input  logic               rst,
	input  ddr_pkg::mem_bus_t  mem,
	input  ddr_pkg::dq_word_t  dq_out,
	input  logic               dq_oe,
	input  logic [1:0]         dqs,
	input  logic               ready,
	output ddr_pkg::dq_word_t  dq_in,
	output logic               proto_err,
	output int                 act_count,
	output int                 ref_count,
	output ddr_pkg::ba_t       act_ba,
	output ddr_pkg::row_t      act_row,
	output ddr_pkg::mem_addr_t rw_addr
);
	import ddr_pkg::*;

	// bank usable again after the burst plus tRP under auto precharge
	localparam int rd_close = `DDR_BURST_LEN + `DDR_T_RP;
	// last write beat, then tWR, then tRP
	localparam int wr_close = `DDR_T_DQSS + `DDR_BURST_LEN + `DDR_T_WR + `DDR_T_RP;
	localparam int worst_xfer = wr_close + `DDR_T_RCD + `DDR_T_RFC + 8;
	localparam int key_w = `DDR_BA_W + `DDR_ROW_W + `DDR_COL_W;

	// beats stored by bank, row and column
	dq_word_t store [logic [key_w-1:0]];
	row_t open_row [4];
	logic [3:0] row_open;
	logic [3:0] c;
	logic [key_w-1:0] rd_key;
	logic [key_w-1:0] wr_key;
	logic [1:0] dqs_prev;
	logic nop_seen;
	logic init_fin;
	int cyc;
	int next_ok;
	string gap_name;
	int init_step;
	int last_ref;
	int last_lmr;
	int rd_at;
	int wr_at;

	task automatic flag(input string msg);
		$display("%s", msg);
		proto_err = 1'b1;
	endtask

	function automatic dq_word_t fetch(input logic [key_w-1:0] k);
		if (store.exists(k)) begin
			return store[k];
		end
		return '0;
	endfunction

	// burst length 2 is code 001
	function automatic logic mode_ok(input mem_addr_t a, input logic dll_rst);
		return a[2:0] == 3'b001 && a[6:4] == `DDR_CAS_CODE && a[8] == dll_rst;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			proto_err = 1'b0;
			act_count = 0;
			ref_count = 0;
			row_open = '0;
			nop_seen = 1'b0;
			init_fin = 1'b0;
			cyc = 0;
			next_ok = 0;
			init_step = 0;
			last_ref = 0;
			last_lmr = 0;
			rd_at = -10;
			wr_at = -10;
			dqs_prev = 2'b00;
			dq_in <= '0;
		end else begin
			cyc = cyc + 1;
			c = mem.cmd;
			if (cyc < `DDR_INIT_WAIT_CYC) begin
				assert (!mem.cke) else flag("CKE went high during the settling wait");
			end
			if (!mem.cke) begin
				assert (c[3] || c == 4'b0111) else flag("command issued while CKE was low");
			end
			if (c == 4'b0111 && mem.cke) begin
				nop_seen = 1'b1;
			end
			// spacing of any real command is set by the one before
			if (!c[3] && c != 4'b0111) begin
				assert (cyc >= next_ok)
					else flag($sformatf("command at %0t breaks %s", $time, gap_name));
			end
			if (!init_fin && !c[3] && c != 4'b0111) begin
				case (init_step)
					0, 3: begin
						assert (c == 4'b0010 && mem.addr[10] && nop_seen)
							else flag("init step is not NOP then precharge-all");
					end
					1: begin
						// DLL enable and full drive are both zero
						assert (c == 4'b0000 && mem.ba == 2'd1 && mem.addr[1:0] == 2'b00)
							else flag("init step is not the extended mode load");
					end
					2, 6: begin
						assert (c == 4'b0000 && mem.ba == 2'd0)
							else flag("init step is not a mode register load");
						assert (mode_ok(mem.addr, init_step == 2))
							else flag($sformatf("Mismatch at %0t: mode word %h", $time, mem.addr));
						last_lmr = cyc;
						if (init_step == 6) begin
							init_fin = 1'b1;
							last_ref = cyc;
						end
					end
					default: begin
						assert (c == 4'b0001) else flag("init step is not an auto refresh");
					end
				endcase
				init_step = init_step + 1;
			end else if (!c[3]) begin
				case (c)
					4'b0011: begin
						assert (!row_open[mem.ba]) else flag("ACTIVE to a bank with an open row");
						open_row[mem.ba] = mem.addr;
						row_open[mem.ba] = 1'b1;
						act_count = act_count + 1;
						act_ba = mem.ba;
						act_row = mem.addr;
					end
					4'b0101, 4'b0100: begin
						assert (row_open[mem.ba]) else flag("READ or WRITE to a closed bank");
						assert (mem.addr[10]) else flag("READ or WRITE without auto precharge");
						rw_addr = mem.addr;
						row_open[mem.ba] = 1'b0;
						if (c[0]) begin
							rd_key = {mem.ba, open_row[mem.ba], mem.addr[`DDR_COL_W-1:0]};
							rd_at = cyc + `DDR_CAS_CYC - 1;
						end else begin
							wr_key = {mem.ba, open_row[mem.ba], mem.addr[`DDR_COL_W-1:0]};
							wr_at = cyc + `DDR_T_DQSS;
						end
					end
					4'b0001: begin
						assert (row_open == '0) else flag("auto refresh while a row was open");
						ref_count = ref_count + 1;
						last_ref = cyc;
					end
					4'b0111: begin
					end
					default: begin
						flag("unexpected command after initialization");
					end
				endcase
			end
			// minimum gap before the next command
			case (c)
				4'b0010: begin
					next_ok = cyc + `DDR_T_RP;
					gap_name = "tRP";
				end
				4'b0001: begin
					next_ok = cyc + `DDR_T_RFC;
					gap_name = "tRFC";
				end
				4'b0000: begin
					next_ok = cyc + `DDR_T_MRD;
					gap_name = "tMRD";
				end
				4'b0011: begin
					next_ok = cyc + `DDR_T_RCD;
					gap_name = "tRCD";
				end
				4'b0101: begin
					next_ok = cyc + rd_close;
					gap_name = "read recovery";
				end
				4'b0100: begin
					next_ok = cyc + wr_close;
					gap_name = "write recovery";
				end
				default: begin
				end
			endcase
			if (ready) begin
				assert (init_fin && cyc - last_lmr >= `DDR_T_MRD)
					else flag("ready rose before initialization finished");
			end
			if (init_fin) begin
				assert (cyc - last_ref <= `DDR_REFRESH_CYC + worst_xfer)
					else flag("auto refresh interval exceeded");
			end
			// read beats with the second one at the other column of the pair
			if (cyc == rd_at) begin
				dq_in <= fetch(rd_key);
			end else if (cyc == rd_at + 1) begin
				dq_in <= fetch(rd_key ^ key_w'(1));
			end
			if (cyc == wr_at || cyc == wr_at + 1) begin
				assert (dq_oe) else flag("dq_oe low during a write beat");
				assert (dqs != dqs_prev) else flag("dqs did not toggle on a write beat");
				store[cyc == wr_at ? wr_key : wr_key ^ key_w'(1)] = dq_out;
			end
			dqs_prev = dqs;
		end
	end

endmodule

// File: dv/ddr_tb.sv
// DDR controller testbench
`timescale 1ns/1ps
`include "ddr_settings.svh"

module ddr_tb;
	import ddr_pkg::*;

	// writes, then two read passes over the same addresses
	localparam int n_xfer = 32;
	localparam int worst_cyc = 48;
	localparam int init_cyc = `DDR_INIT_WAIT_CYC + `DDR_DLL_WAIT_CYC + 200;
	localparam int idle_cyc = 2 * `DDR_REFRESH_CYC + 100;
	localparam int limit_cyc = init_cyc + idle_cyc + (3 * n_xfer + 4) * worst_cyc + 500;

	logic clk;
	logic rst;
	logic cmd_vld;
	logic cmd_write;
	usr_addr_t addr;
	usr_word_t wr_data;
	dq_word_t dq_in;
	mem_bus_t mem;
	dq_word_t dq_out;
	logic dq_oe;
	logic [1:0] dqs;
	usr_word_t rd_data;
	logic rd_vld;
	logic busy;
	logic ready;
	logic proto_err;
	int act_count;
	int ref_count;
	ba_t act_ba;
	row_t act_row;
	mem_addr_t rw_addr;

	usr_addr_t addr_list [n_xfer];
	usr_word_t exp_word [n_xfer];
	usr_word_t got;
	int ref_before;
	int waited;
	logic dup;

	ddr_controller ddr_controller_i (
		.clk (clk), .rst (rst), .cmd_vld (cmd_vld), .cmd_write (cmd_write),
		.addr (addr), .wr_data (wr_data), .dq_in (dq_in), .mem (mem),
		.dq_out (dq_out), .dq_oe (dq_oe), .dqs (dqs), .rd_data (rd_data),
		.rd_vld (rd_vld), .busy (busy), .ready (ready)
	);

	ddr_mem_model ddr_mem_model_i (
		.clk (clk), .rst (rst), .mem (mem), .dq_out (dq_out), .dq_oe (dq_oe),
		.dqs (dqs), .ready (ready), .dq_in (dq_in), .proto_err (proto_err),
		.act_count (act_count), .ref_count (ref_count), .act_ba (act_ba),
		.act_row (act_row), .rw_addr (rw_addr)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	// one cycle, leaves us just after the edge where outputs are settled
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// model findings are picked up half a cycle later
	always @(negedge clk) begin
		assert (!proto_err) else stop_run("memory model found a protocol error");
	end

	task automatic transfer(input logic write, input usr_addr_t a, input usr_word_t d,
			input logic poke, output usr_word_t data);
		int act_before;
		int cnt;
		int vld_seen;
		act_before = act_count;
		cnt = 0;
		vld_seen = 0;
		while (!ready || busy) begin
			step();
			cnt++;
			assert (cnt < worst_cyc) else stop_run("controller stayed busy too long");
		end
		cmd_vld = 1'b1;
		cmd_write = write;
		addr = a;
		wr_data = d;
		step();
		cmd_vld = 1'b0;
		assert (busy) else stop_run($sformatf("Mismatch at %0t: busy low after a strobe", $time));
		cnt = 0;
		while (busy) begin
			step();
			cnt++;
			if (rd_vld) begin
				data = rd_data;
				vld_seen++;
			end
			// a write strobe while busy has to be dropped
			cmd_vld = poke && cnt == 2;
			if (poke && cnt == 2) begin
				cmd_write = 1'b1;
				wr_data = ~d;
			end
			assert (cnt < worst_cyc) else stop_run("busy never fell after a transfer");
		end
		assert (act_count == act_before + 1)
			else stop_run($sformatf("Mismatch at %0t: %0d ACTIVE commands, expected 1",
				$time, act_count - act_before));
		assert (act_ba == (a[`DDR_USR_ADDR_W-1] ? ba_t'(2) : ba_t'(1)) && act_row == a[22:10])
			else stop_run($sformatf("Mismatch at %0t: ACTIVE ba %0d row %h for address %h",
				$time, act_ba, act_row, a));
		assert (rw_addr[9:0] == a[9:0] && rw_addr[10])
			else stop_run($sformatf("Mismatch at %0t: column word %h for address %h",
				$time, rw_addr, a));
		assert (vld_seen == (write ? 0 : 1))
			else stop_run($sformatf("Mismatch at %0t: %0d rd_vld pulses", $time, vld_seen));
	endtask

	initial begin
		#(limit_cyc * 4);
		stop_run("watchdog expired before the tests finished");
	end

	initial begin
		void'($urandom(51963));
		rst = 1'b1;
		cmd_vld = 1'b0;
		cmd_write = 1'b0;
		addr = '0;
		wr_data = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		waited = 0;
		while (!ready) begin
			step();
			waited++;
			assert (waited < init_cyc) else stop_run("ready never rose after reset");
		end
		// distinct addresses, column pair aligned
		for (int i = 0; i < n_xfer; i++) begin
			do begin
				addr_list[i] = usr_addr_t'($urandom) & ~usr_addr_t'(1);
				dup = 1'b0;
				for (int j = 0; j < i; j++) begin
					if (addr_list[j] == addr_list[i]) begin
						dup = 1'b1;
					end
				end
			end while (dup);
			exp_word[i] = $urandom;
		end
		ref_before = ref_count;
		for (int i = 0; i < n_xfer; i++) begin
			transfer(1'b1, addr_list[i], exp_word[i], 1'b0, got);
		end
		for (int i = 0; i < n_xfer; i++) begin
			got = '0;
			transfer(1'b0, addr_list[i], '0, i % 3 == 0, got);
			assert (got == exp_word[i])
				else stop_run($sformatf("Mismatch at %0t: read %h, expected %h",
					$time, got, exp_word[i]));
		end
		assert (ref_count - ref_before >= 2) else stop_run("no refresh during traffic");
		ref_before = ref_count;
		repeat (idle_cyc) step();
		assert (ref_count - ref_before >= 2) else stop_run("no refresh during idle");
		// ignored strobes must have left memory untouched
		for (int i = 0; i < n_xfer; i++) begin
			got = '0;
			transfer(1'b0, addr_list[i], '0, 1'b0, got);
			assert (got == exp_word[i])
				else stop_run($sformatf("Mismatch at %0t: reread %h, expected %h",
					$time, got, exp_word[i]));
		end
		step();
		if (!proto_err) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_run("memory model flagged an error at the end");
		end
	end

endmodule

// File: project.f
+incdir+verilog
verilog/ddr_pkg.sv
verilog/ddr_init_seq.sv
verilog/ddr_cmd_fsm.sv
verilog/ddr_data_path.sv
verilog/ddr_controller.sv
dv/ddr_mem_model.sv
dv/ddr_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal -f project.f --top-module ddr_tb -o ddr_sim \
	&& ./obj_dir/ddr_sim | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
